//--- hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

  parameter int XLEN = 32;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011
  } opcode_t;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL     = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_WORD    = 3'b010; // LW and SW.
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB.

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_PASS_B
  } alu_op_t;

  typedef struct packed {
    logic    valid;
    alu_op_t alu_op;
    logic    use_imm;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    branch;
    logic    branch_ne; // BNE when set, BEQ otherwise.
    logic    uses_rs1;
    logic    uses_rs2;
  } rv32i_control_word;

endpackage : isa_pkg

`default_nettype wire

//--- hdl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  localparam logic [isa_pkg::XLEN-1:0] DEFAULT_RESET_PC = '0;

  typedef struct packed {
    logic                     valid;
    logic [isa_pkg::XLEN-1:0] pc;
    logic [isa_pkg::XLEN-1:0] instr;
  } if_id_t;

  typedef struct packed {
    isa_pkg::rv32i_control_word ctrl;
    logic [isa_pkg::XLEN-1:0]   pc;
    logic [isa_pkg::XLEN-1:0]   rs1_val;
    logic [isa_pkg::XLEN-1:0]   rs2_val;
    logic [isa_pkg::XLEN-1:0]   imm;
    logic [4:0]                 rd;
  } id_ex_t;

  typedef struct packed {
    isa_pkg::rv32i_control_word ctrl;
    logic [isa_pkg::XLEN-1:0]   pc;
    logic [isa_pkg::XLEN-1:0]   alu_result;
    logic [isa_pkg::XLEN-1:0]   rs2_val; // Store data.
    logic [4:0]                 rd;
  } ex_mem_t;

  typedef struct packed {
    isa_pkg::rv32i_control_word ctrl;
    logic [isa_pkg::XLEN-1:0]   pc;
    logic [isa_pkg::XLEN-1:0]   result;
    logic [4:0]                 rd;
  } mem_wb_t;

endpackage : pipe_pkg

`default_nettype wire

//--- hdl/stage_reg.sv
`default_nettype none
`timescale 1ns/100ps

module stage_reg
#(
  parameter type payload_t = logic [31:0]
)
(
  input  logic     clk,
  input  logic     reset,
  input  logic     load,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clk)
  begin
    if (reset || flush)
    begin
      q <= '0; // All-zero payload is a bubble.
    end
    else if (load)
    begin
      q <= d;
    end
  end

endmodule : stage_reg

`default_nettype wire

//--- hdl/fetch_unit.sv
`default_nettype none
`timescale 1ns/100ps

module fetch_unit
#(
  parameter logic [isa_pkg::XLEN-1:0] RESET_PC = pipe_pkg::DEFAULT_RESET_PC
)
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     stall,
  input  logic                     branch_taken,
  input  logic [isa_pkg::XLEN-1:0] branch_target,
  output logic [isa_pkg::XLEN-1:0] pc
);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc <= RESET_PC;
    end
    else if (branch_taken)
    begin
      pc <= branch_target; // Redirect beats stall.
    end
    else if (!stall)
    begin
      pc <= pc + 32'd4;
    end
  end

endmodule : fetch_unit

`default_nettype wire

//--- hdl/decoder.sv
`default_nettype none
`timescale 1ns/100ps

module decoder
(
  input  logic [isa_pkg::XLEN-1:0] instr,
  output isa_pkg::rv32i_control_word ctrl,
  output logic [isa_pkg::XLEN-1:0] imm,
  output logic [4:0]               rs1,
  output logic [4:0]               rs2,
  output logic [4:0]               rd
);

  import isa_pkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] i_imm;
  logic [XLEN-1:0] s_imm;
  logic [XLEN-1:0] b_imm;
  logic [XLEN-1:0] u_imm;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  assign i_imm = {{20{instr[31]}}, instr[31:20]};
  assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign u_imm = {instr[31:12], 12'b0};

  always_comb
  begin
    ctrl = '0;
    imm  = '0;
    case (opcode)
      OPC_OP:
      begin
        ctrl.valid     = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.uses_rs1  = 1'b1;
        ctrl.uses_rs2  = 1'b1;
        case ({funct7, funct3})
          {F7_BASE, F3_ADD_SUB}: ctrl.alu_op = ALU_ADD;
          {F7_ALT, F3_ADD_SUB}:  ctrl.alu_op = ALU_SUB;
          {F7_BASE, F3_SLL}:     ctrl.alu_op = ALU_SLL;
          {F7_BASE, F3_SLT}:     ctrl.alu_op = ALU_SLT;
          {F7_BASE, F3_XOR}:     ctrl.alu_op = ALU_XOR;
          {F7_BASE, F3_SRL}:     ctrl.alu_op = ALU_SRL;
          {F7_BASE, F3_OR}:      ctrl.alu_op = ALU_OR;
          {F7_BASE, F3_AND}:     ctrl.alu_op = ALU_AND;
          default:               ctrl.valid  = 1'b0;
        endcase
      end
      OPC_OP_IMM:
      begin
        ctrl.valid     = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.uses_rs1  = 1'b1;
        ctrl.use_imm   = 1'b1;
        imm            = i_imm;
        case (funct3)
          F3_ADD_SUB: ctrl.alu_op = ALU_ADD;
          F3_SLT:     ctrl.alu_op = ALU_SLT;
          F3_XOR:     ctrl.alu_op = ALU_XOR;
          F3_OR:      ctrl.alu_op = ALU_OR;
          F3_AND:     ctrl.alu_op = ALU_AND;
          default:    ctrl.valid  = 1'b0; // No immediate shifts.
        endcase
      end
      OPC_LUI:
      begin
        ctrl.valid     = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.use_imm   = 1'b1;
        ctrl.alu_op    = ALU_PASS_B;
        imm            = u_imm;
      end
      OPC_LOAD:
      begin
        ctrl.valid     = (funct3 == F3_WORD);
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.uses_rs1  = 1'b1;
        ctrl.use_imm   = 1'b1;
        imm            = i_imm;
      end
      OPC_STORE:
      begin
        ctrl.valid     = (funct3 == F3_WORD);
        ctrl.mem_write = 1'b1;
        ctrl.uses_rs1  = 1'b1;
        ctrl.uses_rs2  = 1'b1;
        ctrl.use_imm   = 1'b1;
        imm            = s_imm;
      end
      OPC_BRANCH:
      begin
        ctrl.valid     = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
        ctrl.branch    = 1'b1;
        ctrl.branch_ne = (funct3 == F3_BNE);
        ctrl.uses_rs1  = 1'b1;
        ctrl.uses_rs2  = 1'b1;
        imm            = b_imm;
      end
      default:
      begin
        ctrl.valid = 1'b0;
      end
    endcase
    if (!ctrl.valid)
    begin
      ctrl = '0; // Unknown encodings travel as a bubble.
    end
  end

endmodule : decoder

`default_nettype wire

//--- hdl/regfile.sv
`default_nettype none
`timescale 1ns/100ps

module regfile
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     we,
  input  logic [4:0]               waddr,
  input  logic [4:0]               raddr1,
  input  logic [4:0]               raddr2,
  input  logic [isa_pkg::XLEN-1:0] wdata,
  output logic [isa_pkg::XLEN-1:0] rdata1,
  output logic [isa_pkg::XLEN-1:0] rdata2
);

  logic [isa_pkg::XLEN-1:0] regs [1:31]; // x0 has no storage.

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 1; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (we && (waddr != 5'd0))
    begin
      regs[waddr] <= wdata;
    end
  end

  always_comb
  begin
    if (raddr1 == 5'd0)
    begin
      rdata1 = '0;
    end
    else if (we && (waddr == raddr1))
    begin
      rdata1 = wdata; // Write-through.
    end
    else
    begin
      rdata1 = regs[raddr1];
    end
  end

  always_comb
  begin
    if (raddr2 == 5'd0)
    begin
      rdata2 = '0;
    end
    else if (we && (waddr == raddr2))
    begin
      rdata2 = wdata;
    end
    else
    begin
      rdata2 = regs[raddr2];
    end
  end

endmodule : regfile

`default_nettype wire

//--- hdl/execute_unit.sv
`default_nettype none
`timescale 1ns/100ps

module execute_unit
(
  input  isa_pkg::rv32i_control_word ctrl,
  input  logic [isa_pkg::XLEN-1:0] pc,
  input  logic [isa_pkg::XLEN-1:0] rs1_val,
  input  logic [isa_pkg::XLEN-1:0] rs2_val,
  input  logic [isa_pkg::XLEN-1:0] imm,
  output logic [isa_pkg::XLEN-1:0] result,
  output logic                     branch_taken,
  output logic [isa_pkg::XLEN-1:0] branch_target
);

  import isa_pkg::*;

  logic [XLEN-1:0] op_b;
  logic            rs_equal;

  assign op_b = ctrl.use_imm ? imm : rs2_val;

  always_comb
  begin
    case (ctrl.alu_op)
      ALU_ADD:    result = rs1_val + op_b;
      ALU_SUB:    result = rs1_val - op_b;
      ALU_AND:    result = rs1_val & op_b;
      ALU_OR:     result = rs1_val | op_b;
      ALU_XOR:    result = rs1_val ^ op_b;
      ALU_SLT:    result = {{(XLEN-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
      ALU_SLL:    result = rs1_val << op_b[4:0];
      ALU_SRL:    result = rs1_val >> op_b[4:0];
      ALU_PASS_B: result = op_b; // LUI.
      default:    result = '0;
    endcase
  end

  assign rs_equal      = (rs1_val == rs2_val);
  assign branch_taken  = ctrl.valid && ctrl.branch && (rs_equal ^ ctrl.branch_ne);
  assign branch_target = pc + imm;

endmodule : execute_unit

`default_nettype wire

//--- hdl/hazard_unit.sv
`default_nettype none
`timescale 1ns/100ps

module hazard_unit
(
  input  logic [4:0] id_rs1,
  input  logic [4:0] id_rs2,
  input  logic       id_uses_rs1,
  input  logic       id_uses_rs2,
  input  logic [4:0] ex_rd,
  input  logic [4:0] mem_rd,
  input  logic       ex_reg_write,
  input  logic       mem_reg_write,
  input  logic       branch_taken,
  output logic       stall,
  output logic       flush
);

  logic rs1_hit;
  logic rs2_hit;

  // Writeback needs no check as the register file reads through.
  assign rs1_hit = id_uses_rs1 && (id_rs1 != 5'd0) &&
                   ((ex_reg_write && (ex_rd == id_rs1)) ||
                    (mem_reg_write && (mem_rd == id_rs1)));
  assign rs2_hit = id_uses_rs2 && (id_rs2 != 5'd0) &&
                   ((ex_reg_write && (ex_rd == id_rs2)) ||
                    (mem_reg_write && (mem_rd == id_rs2)));

  assign flush = branch_taken;
  assign stall = (rs1_hit || rs2_hit) && !branch_taken; // Flush wins.

endmodule : hazard_unit

`default_nettype wire

//--- hdl/rv32i_pipe_top.sv
`default_nettype none
`timescale 1ns/100ps

module rv32i_pipe_top
#(
  parameter logic [isa_pkg::XLEN-1:0] RESET_PC = pipe_pkg::DEFAULT_RESET_PC
)
(
  input  logic                     clk,
  input  logic                     reset,
  output logic [isa_pkg::XLEN-1:0] imem_addr,
  input  logic [isa_pkg::XLEN-1:0] imem_rdata,
  output logic [isa_pkg::XLEN-1:0] dmem_addr,
  output logic [isa_pkg::XLEN-1:0] dmem_wdata,
  output logic                     dmem_we,
  input  logic [isa_pkg::XLEN-1:0] dmem_rdata,
  output logic                     wb_valid,
  output logic [isa_pkg::XLEN-1:0] wb_pc,
  output logic [4:0]               wb_rd,
  output logic [isa_pkg::XLEN-1:0] wb_data
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic [XLEN-1:0]   pc;
  logic              stall;
  logic              flush;
  logic              branch_taken;
  logic [XLEN-1:0]   branch_target;

  rv32i_control_word dec_ctrl;
  logic [XLEN-1:0]   dec_imm;
  logic [4:0]        dec_rs1;
  logic [4:0]        dec_rs2;
  logic [4:0]        dec_rd;
  logic [XLEN-1:0]   rs1_val;
  logic [XLEN-1:0]   rs2_val;
  logic [XLEN-1:0]   ex_result;

  if_id_t            if_id_d, if_id_q;
  id_ex_t            id_ex_d, id_ex_q;
  ex_mem_t           ex_mem_d, ex_mem_q;
  mem_wb_t           mem_wb_d, mem_wb_q;

  fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
    .clk           (clk),
    .reset         (reset),
    .stall         (stall),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .pc            (pc)
  );

  assign imem_addr = pc;

  always_comb
  begin
    if_id_d.valid = 1'b1;
    if_id_d.pc    = pc;
    if_id_d.instr = imem_rdata;
  end

  stage_reg #(.payload_t(if_id_t)) u_if_id (
    .clk (clk), .reset (reset), .load (!stall), .flush (flush), .d (if_id_d), .q (if_id_q)
  );

  decoder u_decoder (
    .instr (if_id_q.instr),
    .ctrl  (dec_ctrl),
    .imm   (dec_imm),
    .rs1   (dec_rs1),
    .rs2   (dec_rs2),
    .rd    (dec_rd)
  );

  regfile u_regfile (
    .clk    (clk),
    .reset  (reset),
    .we     (wb_valid),
    .waddr  (mem_wb_q.rd),
    .raddr1 (dec_rs1),
    .raddr2 (dec_rs2),
    .wdata  (mem_wb_q.result),
    .rdata1 (rs1_val),
    .rdata2 (rs2_val)
  );

  hazard_unit u_hazard (
    .id_rs1        (dec_rs1),
    .id_rs2        (dec_rs2),
    .id_uses_rs1   (if_id_q.valid && dec_ctrl.uses_rs1),
    .id_uses_rs2   (if_id_q.valid && dec_ctrl.uses_rs2),
    .ex_rd         (id_ex_q.rd),
    .mem_rd        (ex_mem_q.rd),
    .ex_reg_write  (id_ex_q.ctrl.reg_write),
    .mem_reg_write (ex_mem_q.ctrl.reg_write),
    .branch_taken  (branch_taken),
    .stall         (stall),
    .flush         (flush)
  );

  always_comb
  begin
    id_ex_d.ctrl    = if_id_q.valid ? dec_ctrl : '0;
    id_ex_d.pc      = if_id_q.pc;
    id_ex_d.rs1_val = rs1_val;
    id_ex_d.rs2_val = rs2_val;
    id_ex_d.imm     = dec_imm;
    id_ex_d.rd      = dec_rd;
  end

  // A stall leaves a bubble behind decode.
  stage_reg #(.payload_t(id_ex_t)) u_id_ex (
    .clk (clk), .reset (reset), .load (1'b1), .flush (flush || stall), .d (id_ex_d), .q (id_ex_q)
  );

  execute_unit u_execute (
    .ctrl          (id_ex_q.ctrl),
    .pc            (id_ex_q.pc),
    .rs1_val       (id_ex_q.rs1_val),
    .rs2_val       (id_ex_q.rs2_val),
    .imm           (id_ex_q.imm),
    .result        (ex_result),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  always_comb
  begin
    ex_mem_d.ctrl       = id_ex_q.ctrl;
    ex_mem_d.pc         = id_ex_q.pc;
    ex_mem_d.alu_result = ex_result;
    ex_mem_d.rs2_val    = id_ex_q.rs2_val;
    ex_mem_d.rd         = id_ex_q.rd;
  end

  stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
    .clk (clk), .reset (reset), .load (1'b1), .flush (1'b0), .d (ex_mem_d), .q (ex_mem_q)
  );

  assign dmem_addr  = ex_mem_q.alu_result;
  assign dmem_wdata = ex_mem_q.rs2_val;
  assign dmem_we    = ex_mem_q.ctrl.mem_write;

  always_comb
  begin
    mem_wb_d.ctrl   = ex_mem_q.ctrl;
    mem_wb_d.pc     = ex_mem_q.pc;
    mem_wb_d.result = ex_mem_q.ctrl.mem_read ? dmem_rdata : ex_mem_q.alu_result;
    mem_wb_d.rd     = ex_mem_q.rd;
  end

  stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
    .clk (clk), .reset (reset), .load (1'b1), .flush (1'b0), .d (mem_wb_d), .q (mem_wb_q)
  );

  assign wb_valid = mem_wb_q.ctrl.valid && mem_wb_q.ctrl.reg_write;
  assign wb_pc    = mem_wb_q.pc;
  assign wb_rd    = mem_wb_q.rd;
  assign wb_data  = mem_wb_q.result;

endmodule : rv32i_pipe_top

`default_nettype wire

//--- dv/tb_clock.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clock
#(
  parameter int PERIOD_NS = 4
)
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule : tb_clock

`default_nettype wire

//--- dv/rv32i_pipe_tb.sv
`default_nettype none
`timescale 1ns/100ps

module rv32i_pipe_tb;

  import pipe_pkg::*;

  localparam int NUM_TESTS    = 5;
  localparam int PROG_LEN     = 40;
  localparam int DMEM_WORDS   = 16;
  localparam int RESET_CYCLES = 5;
  localparam int CYCLE_LIMIT  = NUM_TESTS * (4 * PROG_LEN + 50 + RESET_CYCLES + 1);

  localparam logic [31:0] PROG_BASE  = DEFAULT_RESET_PC;
  localparam logic [31:0] PROG_BYTES = 32'(PROG_LEN * 4);
  localparam logic [31:0] NOP_WORD   = 32'h0000_0013; // ADDI x0, x0, 0.

  // Instruction kinds of the generated programs.
  localparam int K_ADD  = 0;
  localparam int K_SUB  = 1;
  localparam int K_AND  = 2;
  localparam int K_OR   = 3;
  localparam int K_XOR  = 4;
  localparam int K_SLT  = 5;
  localparam int K_SLL  = 6;
  localparam int K_SRL  = 7;
  localparam int K_ADDI = 8;
  localparam int K_ANDI = 9;
  localparam int K_ORI  = 10;
  localparam int K_XORI = 11;
  localparam int K_SLTI = 12;
  localparam int K_LUI  = 13;
  localparam int K_LW   = 14;
  localparam int K_SW   = 15;
  localparam int K_BEQ  = 16;
  localparam int K_BNE  = 17;

  logic        clk;
  logic        reset = 1'b1;
  logic [31:0] imem_addr;
  logic [31:0] imem_rdata;
  logic [31:0] imem_offset;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_we;
  logic [31:0] dmem_rdata;
  logic        wb_valid;
  logic [31:0] wb_pc;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;

  integer      seed;
  int          test_id = 0;
  int          total_errors;
  int          failed_tests;
  int          cycle_count = 0;

  logic [31:0] imem [0:PROG_LEN-1];
  logic [31:0] dmem [0:DMEM_WORDS-1];
  logic [31:0] model_mem [0:DMEM_WORDS-1];
  int          prog_kind [0:PROG_LEN-1];
  int          prog_rd [0:PROG_LEN-1];
  int          prog_rs1 [0:PROG_LEN-1];
  int          prog_rs2 [0:PROG_LEN-1];
  int          prog_imm [0:PROG_LEN-1];

  logic [31:0] exp_pc [$];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];

  tb_clock #(.PERIOD_NS(4)) clock_gen (.clk(clk));

  rv32i_pipe_top #(.RESET_PC(DEFAULT_RESET_PC)) dut (
    .clk        (clk),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata),
    .wb_valid   (wb_valid),
    .wb_pc      (wb_pc),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

  // Both memories answer in the same cycle.
  assign imem_offset = imem_addr - PROG_BASE;
  assign imem_rdata  = (imem_offset < PROG_BYTES) ? imem[imem_offset[7:2]] : NOP_WORD;
  assign dmem_rdata  = dmem[dmem_addr[5:2]];

  function automatic logic [31:0] fill_word(input int t, input int i);
    logic [31:0] addr;
    addr = 32'(i) << 2;
    return (addr * 32'h9E37_79B1) ^ (32'h0101_0101 * 32'(t + 1));
  endfunction

  always @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < DMEM_WORDS; i++)
      begin
        dmem[i] <= fill_word(test_id, i);
      end
    end
    else if (dmem_we)
    begin
      dmem[dmem_addr[5:2]] <= dmem_wdata;
    end
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
      $display("** FAIL **");
      $finish;
    end
  end

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return r % n;
  endfunction

  function automatic string test_label(input int t);
    case (t)
      0: return "alu_only";
      1: return "dependent_chain";
      2: return "load_store";
      3: return "branches";
      default: return "mixed";
    endcase
  endfunction

  function automatic logic [31:0] instr_word(input int kind, input int rd, input int rs1,
                                             input int rs2, input int imm);
    logic [31:0] v;
    logic [4:0]  d;
    logic [4:0]  s1;
    logic [4:0]  s2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    v  = imm;
    d  = 5'(rd);
    s1 = 5'(rs1);
    s2 = 5'(rs2);
    f7 = (kind == K_SUB) ? 7'b0100000 : 7'b0000000;
    case (kind)
      K_ADD, K_SUB, K_ADDI, K_BEQ: f3 = 3'b000;
      K_SLL, K_BNE:                f3 = 3'b001;
      K_SLT, K_SLTI, K_LW, K_SW:   f3 = 3'b010;
      K_XOR, K_XORI:               f3 = 3'b100;
      K_SRL:                       f3 = 3'b101;
      K_OR, K_ORI:                 f3 = 3'b110;
      default:                     f3 = 3'b111;
    endcase
    if (kind <= K_SRL)
    begin
      return {f7, s2, s1, f3, d, 7'b0110011};
    end
    else if (kind <= K_SLTI)
    begin
      return {v[11:0], s1, f3, d, 7'b0010011};
    end
    else if (kind == K_LUI)
    begin
      return {v[31:12], d, 7'b0110111};
    end
    else if (kind == K_LW)
    begin
      return {v[11:0], s1, f3, d, 7'b0000011};
    end
    else if (kind == K_SW)
    begin
      return {v[11:5], s2, s1, f3, v[4:0], 7'b0100011};
    end
    return {v[12], v[10:5], s2, s1, f3, v[4:1], v[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] alu_ref(input int kind, input logic [31:0] a,
                                          input logic [31:0] b);
    case (kind)
      K_ADD, K_ADDI: return a + b;
      K_SUB:         return a - b;
      K_AND, K_ANDI: return a & b;
      K_OR, K_ORI:   return a | b;
      K_XOR, K_XORI: return a ^ b;
      K_SLT, K_SLTI: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      K_SLL:         return a << b[4:0];
      default:       return a >> b[4:0];
    endcase
  endfunction

  task automatic build_program(input int mode);
    int kind;
    int rd;
    int rs1;
    int rs2;
    int imm;
    int pick;
    int prev_rd;
    prev_rd = 1 + rand_below(7);
    for (int i = 0; i < PROG_LEN; i++)
    begin
      rd  = rand_below(8); // Few registers keep dependencies frequent.
      rs1 = rand_below(8);
      rs2 = rand_below(8);
      case (mode)
        0: kind = rand_below(K_LUI + 1);
        1:
        begin
          kind = rand_below(K_SLTI + 1);
          rd   = 1 + rand_below(7);
          rs1  = prev_rd;
          if (rand_below(2) == 0)
          begin
            rs2 = prev_rd;
          end
          prev_rd = rd;
        end
        2:
        begin
          pick = rand_below(4);
          kind = (pick == 0) ? K_ADDI : (pick == 1) ? K_LUI : (pick == 2) ? K_LW : K_SW;
          rd   = 1 + rand_below(7);
        end
        3:
        begin
          kind = (rand_below(5) < 2) ? K_BEQ + rand_below(2) : K_ADDI;
          rd   = 1 + rand_below(3);
          rs1  = rand_below(4);
          rs2  = rand_below(4);
        end
        default: kind = rand_below(K_BNE + 1);
      endcase
      if (kind >= K_ADDI && kind <= K_SLTI)
      begin
        imm = (mode == 3) ? rand_below(2) : rand_below(4096) - 2048; // Small values tie often.
      end
      else if (kind == K_LUI)
      begin
        imm = rand_below(1 << 20) << 12;
      end
      else if (kind == K_LW || kind == K_SW)
      begin
        rs1 = 0;
        imm = 4 * rand_below(DMEM_WORDS);
      end
      else if (kind >= K_BEQ)
      begin
        imm = 4 * (2 + rand_below(3)); // Forward only.
      end
      else
      begin
        imm = 0;
      end
      prog_kind[i] = kind;
      prog_rd[i]   = rd;
      prog_rs1[i]  = rs1;
      prog_rs2[i]  = rs2;
      prog_imm[i]  = imm;
      imem[i]      = instr_word(kind, rd, rs1, rs2, imm);
    end
  endtask

  task automatic run_model(input int t);
    logic [31:0] regs [0:7];
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_v;
    logic [31:0] addr;
    logic [31:0] res;
    int          idx;
    int          kind;
    exp_pc.delete();
    exp_rd.delete();
    exp_data.delete();
    for (int i = 0; i < DMEM_WORDS; i++)
    begin
      model_mem[i] = fill_word(t, i);
    end
    for (int r = 0; r < 8; r++)
    begin
      regs[r] = '0;
    end
    pc = PROG_BASE;
    while ((pc - PROG_BASE) < PROG_BYTES)
    begin
      idx     = int'((pc - PROG_BASE) >> 2);
      kind    = prog_kind[idx];
      a       = regs[prog_rs1[idx]];
      b       = regs[prog_rs2[idx]];
      imm_v   = prog_imm[idx];
      addr    = a + imm_v;
      next_pc = pc + 32'd4;
      res     = '0;
      case (kind)
        K_LUI: res = imm_v;
        K_LW:  res = model_mem[addr[5:2]];
        K_SW:  model_mem[addr[5:2]] = b;
        K_BEQ: next_pc = (a == b) ? pc + imm_v : next_pc;
        K_BNE: next_pc = (a != b) ? pc + imm_v : next_pc;
        default: res = alu_ref(kind, a, (kind <= K_SRL) ? b : imm_v);
      endcase
      if (kind <= K_LW)
      begin
        exp_pc.push_back(pc);
        exp_rd.push_back(5'(prog_rd[idx]));
        exp_data.push_back(res);
        if (prog_rd[idx] != 0)
        begin
          regs[prog_rd[idx]] = res; // x0 keeps zero.
        end
      end
      pc = next_pc;
    end
  endtask

  task automatic check_writeback();
    assert (exp_pc.size() > 0)
    else
    begin
      $display("[ERROR] t=%0t: writeback at pc %h with no expected entry left", $time, wb_pc);
      total_errors++;
    end
    if (exp_pc.size() > 0)
    begin
      assert (wb_pc == exp_pc[0] && wb_rd == exp_rd[0] && wb_data == exp_data[0])
      else
      begin
        $display("[ERROR] t=%0t: writeback pc %h x%0d = %h, expected pc %h x%0d = %h",
                 $time, wb_pc, wb_rd, wb_data, exp_pc[0], exp_rd[0], exp_data[0]);
        total_errors++;
      end
      void'(exp_pc.pop_front());
      void'(exp_rd.pop_front());
      void'(exp_data.pop_front());
    end
  endtask

  task automatic run_test(input int t);
    int errors_before;
    int retired;
    int expected;
    bit done;
    test_id       = t;
    errors_before = total_errors;
    @(posedge clk);
    reset <= 1'b1;
    build_program(t);
    run_model(t);
    expected = exp_pc.size();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    retired = 0;
    done    = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      if (wb_valid)
      begin
        if ((wb_pc - PROG_BASE) >= PROG_BYTES)
        begin
          done = 1'b1; // Every older instruction retires before the first NOP past the program.
        end
        else
        begin
          check_writeback();
          retired++;
        end
      end
    end
    assert (retired == expected)
    else
    begin
      $display("[ERROR] t=%0t: %0d writebacks retired, expected %0d", $time, retired, expected);
      total_errors++;
    end
    for (int i = 0; i < DMEM_WORDS; i++)
    begin
      assert (dmem[i] == model_mem[i])
      else
      begin
        $display("[ERROR] t=%0t: dmem word %0d is %h, expected %h",
                 $time, i, dmem[i], model_mem[i]);
        total_errors++;
      end
    end
    if (total_errors != errors_before)
    begin
      failed_tests++;
    end
    $display("Test %0d %s: %0d writebacks, %0d errors",
             t, test_label(t), retired, total_errors - errors_before);
  endtask

  initial
  begin
    seed         = 68;
    total_errors = 0;
    failed_tests = 0;
    for (int t = 0; t < NUM_TESTS; t++)
    begin
      run_test(t);
    end
    $display("Summary: %0d tests, %0d failed, %0d errors", NUM_TESTS, failed_tests,
             total_errors);
    if (total_errors == 0)
    begin
      $display("** PASS **");
    end
    else
    begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : rv32i_pipe_tb

`default_nettype wire

//--- compile.f
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/stage_reg.sv
hdl/fetch_unit.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/execute_unit.sv
hdl/hazard_unit.sv
hdl/rv32i_pipe_top.sv
dv/tb_clock.sv
dv/rv32i_pipe_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module rv32i_pipe_tb \
  -f compile.f -Mdir obj_dir -o rv32i_pipe_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rv32i_pipe_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi
exit 0
